// ==== hdl/sampler_settings.svh ====
/* fixed widths, depths and the modulus of the coefficient sampler
   included by the package and by each RTL module that needs one of the values */
`ifndef SAMPLER_SETTINGS_SVH
`define SAMPLER_SETTINGS_SVH

// squeeze side
`define SQZ_W        64
`define FIFO_DEPTH   4

// sample widths per mode
`define UNI_SAMPLE_W 24
`define BND_SAMPLE_W 4

// ML-DSA modulus
`define Q_W          23
`define Q_VALUE      8380417

// one operation
`define COEFF_CNT    256
`define ADDR_W       10

`endif

// ==== hdl/sampler_pkg.sv ====
/* shared types of the coefficient sampler
   imported by every RTL module below the top level */
`default_nettype none
`include "sampler_settings.svh"

package sampler_pkg;

  typedef logic [`SQZ_W-1:0]        sqz_word_t;

  // bounded samples sit in the low bits of the widest sample
  typedef logic [`UNI_SAMPLE_W-1:0] sample_t;

  typedef logic [`Q_W-1:0]          coeff_t;
  typedef logic [`ADDR_W-1:0]       addr_t;

  typedef enum logic {
    MODE_UNIFORM = 1'b0,
    MODE_BOUNDED = 1'b1
  } sampler_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/sampler_ctrl_if.sv ====
/* operation control from the controller to the datapath, accept events back */
`default_nettype none

interface sampler_ctrl_if
  import sampler_pkg::*;
  ();

  sampler_mode_e mode;
  logic          run;
  logic          clear;
  logic          coeff_accept;

  modport ctrl (
    output mode,
    output run,
    output clear,
    input  coeff_accept
  );

  // fifo and piso only need the flush and the sample width
  modport piso (
    input clear,
    input mode
  );

  modport sampler (
    input  mode,
    input  run,
    output coeff_accept
  );

endinterface

`default_nettype wire

// ==== hdl/squeeze_fifo.sv ====
/* four-entry buffer for incoming squeeze words under credit flow control
   returns one credit per word that leaves, popped or discarded by a clear */
`default_nettype none
`include "sampler_settings.svh"

module squeeze_fifo
  import sampler_pkg::*;
(
  input  logic         clk,
  input  logic         rst_b,
  input  logic         sqz_valid_i,
  input  sqz_word_t    sqz_data_i,
  input  logic         word_pop_i,
  output logic         word_valid_o,
  output sqz_word_t    word_data_o,
  output logic         sqz_credit_o,
  sampler_ctrl_if.piso ctl
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  sqz_word_t        mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] owed_q;
  logic [CNT_W-1:0] owed;
  logic             push;
  logic             pop;
  logic             credit;

  // a word arriving with clear is dropped but its credit is still owed
  assign push = sqz_valid_i & ~ctl.clear;
  assign pop  = word_pop_i & word_valid_o & ~ctl.clear;

  assign word_valid_o = (count != '0);
  assign word_data_o  = mem[rd_ptr];

  always_comb begin
    owed = owed_q + CNT_W'(pop);
    if (ctl.clear) begin
      owed = owed + count + CNT_W'(sqz_valid_i);
    end
    // at most one credit pulse per cycle
    credit = (owed != '0);
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      owed_q       <= '0;
      sqz_credit_o <= 1'b0;
    end else begin
      owed_q       <= owed - CNT_W'(credit);
      sqz_credit_o <= credit;
      if (ctl.clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        count <= count + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= sqz_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/chunk_piso.sv ====
/* cuts 64-bit squeeze words into 24-bit or 4-bit samples, low bits first
   the sample width follows the mode latched by the controller */
`default_nettype none
`include "sampler_settings.svh"

module chunk_piso
  import sampler_pkg::*;
(
  input  logic         clk,
  input  logic         rst_b,
  input  logic         word_valid_i,
  input  sqz_word_t    word_data_i,
  output logic         word_pop_o,
  output logic         sample_valid_o,
  output sample_t      sample_data_o,
  sampler_ctrl_if.piso ctl
);

  // one word on top of a partly used uniform sample
  localparam int BUF_W = `SQZ_W + `UNI_SAMPLE_W;
  localparam int CNT_W = $clog2(BUF_W + 1);

  logic [BUF_W-1:0] buf_q;
  logic [BUF_W-1:0] buf_nx;
  logic [CNT_W-1:0] bits_q;
  logic [CNT_W-1:0] bits_nx;
  logic [CNT_W-1:0] take;
  logic [CNT_W-1:0] rest;
  logic             emit;
  logic             load;

  always_comb begin
    take = (ctl.mode == MODE_UNIFORM) ? CNT_W'(`UNI_SAMPLE_W) : CNT_W'(`BND_SAMPLE_W);
    emit = ~ctl.clear & (bits_q >= take);
    load = ~ctl.clear & word_valid_i & (bits_q <= CNT_W'(`UNI_SAMPLE_W));
    rest = emit ? bits_q - take : bits_q;

    buf_nx = emit ? (buf_q >> take) : buf_q;
    // new word goes right above the bits still held
    if (load) begin
      buf_nx = buf_nx | (BUF_W'(word_data_i) << rest);
    end
    bits_nx = load ? rest + CNT_W'(`SQZ_W) : rest;
  end

  assign word_pop_o     = load;
  assign sample_valid_o = emit;
  assign sample_data_o  = (ctl.mode == MODE_UNIFORM) ?
                          buf_q[`UNI_SAMPLE_W-1:0] :
                          {{(`UNI_SAMPLE_W - `BND_SAMPLE_W){1'b0}},
                           buf_q[`BND_SAMPLE_W-1:0]};

  // the load relies on zero bits above the count
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buf_q  <= '0;
      bits_q <= '0;
    end else if (ctl.clear) begin
      buf_q  <= '0;
      bits_q <= '0;
    end else begin
      buf_q  <= buf_nx;
      bits_q <= bits_nx;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/coeff_sampler.sv ====
/* rejection rule of the current mode on each offered sample
   an accepted result is registered and flagged to the controller */
`default_nettype none
`include "sampler_settings.svh"

module coeff_sampler
  import sampler_pkg::*;
(
  input  logic            clk,
  input  logic            rst_b,
  input  logic            sample_valid_i,
  input  sample_t         sample_data_i,
  output logic            coeff_valid_o,
  output coeff_t          coeff_o,
  sampler_ctrl_if.sampler ctl
);

  localparam coeff_t Q = coeff_t'(`Q_VALUE);
  localparam logic [`BND_SAMPLE_W-1:0] BND_LIMIT = 4'd15;

  coeff_t                   uni_val;
  logic [`BND_SAMPLE_W-1:0] nib;
  logic [2:0]               nib_mod5;
  coeff_t                   bnd_val;
  coeff_t                   value;
  logic                     keep;
  logic                     accept;

  always_comb begin
    // top sample bit is masked off
    uni_val  = sample_data_i[`Q_W-1:0];
    nib      = sample_data_i[`BND_SAMPLE_W-1:0];
    nib_mod5 = 3'(nib % 5);
    // 2 - (n mod 5) wrapped into [0, q)
    if (nib_mod5 <= 3'd2) begin
      bnd_val = coeff_t'(3'd2 - nib_mod5);
    end else begin
      bnd_val = Q + coeff_t'(2) - coeff_t'(nib_mod5);
    end
    if (ctl.mode == MODE_UNIFORM) begin
      keep  = (uni_val < Q);
      value = uni_val;
    end else begin
      keep  = (nib < BND_LIMIT);
      value = bnd_val;
    end
  end

  assign accept = sample_valid_i & ctl.run & keep;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      coeff_valid_o <= 1'b0;
    end else begin
      coeff_valid_o <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      coeff_o <= value;
    end
  end

  assign ctl.coeff_accept = coeff_valid_o;

endmodule

`default_nettype wire

// ==== hdl/sampler_ctrl.sv ====
/* operation FSM of the sampler with start, coefficient count and destination address
   drives run, clear and the latched mode to the datapath */
`default_nettype none
`include "sampler_settings.svh"

module sampler_ctrl
  import sampler_pkg::*;
(
  input  logic          clk,
  input  logic          rst_b,
  input  logic          start_i,
  input  sampler_mode_e mode_i,
  input  addr_t         dest_base_i,
  output logic          busy_o,
  output logic          done_o,
  output addr_t         coeff_addr_o,
  sampler_ctrl_if.ctrl  ctl
);

  localparam int CNT_W = $clog2(`COEFF_CNT);

  ctrl_state_e      state_q;
  ctrl_state_e      state_nx;
  logic [CNT_W-1:0] cnt_q;
  sampler_mode_e    mode_q;
  logic             first_q;
  logic             start_ok;
  logic             last;

  assign busy_o   = (state_q == ST_RUN);
  assign done_o   = (state_q == ST_DONE);
  assign start_ok = start_i & ~busy_o;

  // 256th coefficient is on the output this cycle
  assign last = ctl.coeff_accept & (cnt_q == CNT_W'(`COEFF_CNT - 1));

  assign ctl.mode = mode_q;
  // stop sampling as soon as the last one is out
  assign ctl.run   = busy_o & ~first_q & ~last;
  assign ctl.clear = first_q | done_o;

  always_comb begin
    state_nx = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (start_ok) begin
          state_nx = ST_RUN;
        end
      end
      ST_RUN: begin
        if (last) begin
          state_nx = ST_DONE;
        end
      end
      ST_DONE: begin
        state_nx = start_ok ? ST_RUN : ST_IDLE;
      end
      default: begin
        state_nx = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q      <= ST_IDLE;
      first_q      <= 1'b0;
      cnt_q        <= '0;
      mode_q       <= MODE_UNIFORM;
      coeff_addr_o <= '0;
    end else begin
      state_q <= state_nx;
      first_q <= start_ok;
      if (start_ok) begin
        cnt_q        <= '0;
        mode_q       <= mode_i;
        coeff_addr_o <= dest_base_i;
      end else if (ctl.coeff_accept) begin
        cnt_q        <= cnt_q + 1'b1;
        coeff_addr_o <= coeff_addr_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sampler_top.sv ====
/* top level of the coefficient sampler that takes squeeze words in
   and sends coefficients with destination addresses out */
`default_nettype none

module sampler_top (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       start_i,
  input  sampler_pkg::sampler_mode_e mode_i,
  input  sampler_pkg::addr_t         dest_base_i,
  input  logic                       sqz_valid_i,
  input  sampler_pkg::sqz_word_t     sqz_data_i,
  output logic                       sqz_credit_o,
  output logic                       busy_o,
  output logic                       done_o,
  output logic                       coeff_valid_o,
  output sampler_pkg::coeff_t        coeff_o,
  output sampler_pkg::addr_t         coeff_addr_o
);

  logic                   word_valid;
  logic                   word_pop;
  sampler_pkg::sqz_word_t word_data;
  logic                   sample_valid;
  sampler_pkg::sample_t   sample_data;

  sampler_ctrl_if ctl_if ();

  sampler_ctrl u_sampler_ctrl (
    .clk          (clk),
    .rst_b        (rst_b),
    .start_i      (start_i),
    .mode_i       (mode_i),
    .dest_base_i  (dest_base_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .coeff_addr_o (coeff_addr_o),
    .ctl          (ctl_if.ctrl)
  );

  squeeze_fifo u_squeeze_fifo (
    .clk          (clk),
    .rst_b        (rst_b),
    .sqz_valid_i  (sqz_valid_i),
    .sqz_data_i   (sqz_data_i),
    .word_pop_i   (word_pop),
    .word_valid_o (word_valid),
    .word_data_o  (word_data),
    .sqz_credit_o (sqz_credit_o),
    .ctl          (ctl_if.piso)
  );

  chunk_piso u_chunk_piso (
    .clk            (clk),
    .rst_b          (rst_b),
    .word_valid_i   (word_valid),
    .word_data_i    (word_data),
    .word_pop_o     (word_pop),
    .sample_valid_o (sample_valid),
    .sample_data_o  (sample_data),
    .ctl            (ctl_if.piso)
  );

  coeff_sampler u_coeff_sampler (
    .clk            (clk),
    .rst_b          (rst_b),
    .sample_valid_i (sample_valid),
    .sample_data_i  (sample_data),
    .coeff_valid_o  (coeff_valid_o),
    .coeff_o        (coeff_o),
    .ctl            (ctl_if.sampler)
  );

endmodule

`default_nettype wire

// ==== bench/sampler_properties.sv ====
/* concurrent checks on the sampler top-level ports
   bound into sampler_top by the testbench */
`default_nettype none
`include "sampler_settings.svh"

module sampler_properties
  import sampler_pkg::*;
(
  input logic   clk,
  input logic   rst_b,
  input logic   busy_o,
  input logic   done_o,
  input logic   coeff_valid_o,
  input coeff_t coeff_o
);

  // coefficients only flow inside an operation
  a_valid_in_busy: assert property (
    @(posedge clk) disable iff (!rst_b)
    coeff_valid_o |-> busy_o
  ) else $error("coeff_valid_o high while busy_o is low");

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_b)
    done_o |=> !done_o
  ) else $error("done_o held for more than one cycle");

  // reduced mod q in both modes
  a_coeff_range: assert property (
    @(posedge clk) disable iff (!rst_b)
    coeff_valid_o |-> (coeff_o < `Q_VALUE)
  ) else $error("coefficient not below the modulus");

  a_ctrl_known: assert property (
    @(posedge clk) disable iff (!rst_b)
    !$isunknown({busy_o, done_o})
  ) else $error("busy_o or done_o unknown after reset");

endmodule

`default_nettype wire

// ==== bench/tb_sampler_top.sv ====
/* testbench for the coefficient sampler with random squeeze words under credit flow,
   a reference model of both rejection rules and six operations in alternating modes */
`default_nettype none
`include "sampler_settings.svh"

module tb_sampler_top
  import sampler_pkg::*;
();

  // six operations of at most 2000 cycles each
  localparam int TIMEOUT_CYCLES = 12000;
  localparam int IDLE_GAP       = 8;

  logic          clk;
  logic          rst_b;
  logic          start_i;
  sampler_mode_e mode_i;
  addr_t         dest_base_i;
  logic          sqz_valid_i;
  sqz_word_t     sqz_data_i;
  logic          sqz_credit_o;
  logic          busy_o;
  logic          done_o;
  logic          coeff_valid_o;
  coeff_t        coeff_o;
  addr_t         coeff_addr_o;

  integer        seed;
  int            cycle_count;
  int            credits;
  // 0 idle, 1 start issued, 2 running, 3 done expected
  int            phase;
  int            got;
  int            produced;
  bit            start_req;
  bit            inject_ones;
  sampler_mode_e cur_mode;
  addr_t         cur_base;
  string         test_name;
  logic [127:0]  mbuf;
  int            mbits;
  int unsigned   exp_coeff[$];
  int unsigned   exp_addr[$];

  sampler_top u_sampler_top (
    .clk           (clk),
    .rst_b         (rst_b),
    .start_i       (start_i),
    .mode_i        (mode_i),
    .dest_base_i   (dest_base_i),
    .sqz_valid_i   (sqz_valid_i),
    .sqz_data_i    (sqz_data_i),
    .sqz_credit_o  (sqz_credit_o),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .coeff_valid_o (coeff_valid_o),
    .coeff_o       (coeff_o),
    .coeff_addr_o  (coeff_addr_o)
  );

  bind sampler_top sampler_properties u_sampler_properties (
    .clk           (clk),
    .rst_b         (rst_b),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .coeff_valid_o (coeff_valid_o),
    .coeff_o       (coeff_o)
  );

  always #50 clk = ~clk;

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s %s: expected %0h actual %0h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // append a word above the leftover bits and cut out whole samples
  task automatic model_word(input sqz_word_t word);
    int          width;
    logic [23:0] smp;
    int unsigned val;
    mbuf  = mbuf | ({64'b0, word} << mbits);
    mbits = mbits + 64;
    width = (cur_mode == MODE_UNIFORM) ? `UNI_SAMPLE_W : `BND_SAMPLE_W;
    while (mbits >= width) begin
      smp   = (cur_mode == MODE_UNIFORM) ? mbuf[23:0] : {20'b0, mbuf[3:0]};
      mbuf  = mbuf >> width;
      mbits = mbits - width;
      if (cur_mode == MODE_UNIFORM) begin
        val = smp & 32'h007f_ffff;
        if (val < `Q_VALUE && produced < `COEFF_CNT) begin
          exp_coeff.push_back(val);
          exp_addr.push_back((cur_base + produced) & 32'h3ff);
          produced++;
        end
      end else if (smp[3:0] < 15 && produced < `COEFF_CNT) begin
        val = (`Q_VALUE + 2 - (smp[3:0] % 5)) % `Q_VALUE;
        exp_coeff.push_back(val);
        exp_addr.push_back((cur_base + produced) & 32'h3ff);
        produced++;
      end
    end
  endtask

  // observe the cycle that just ended, then drive the next one
  task automatic step_cycle();
    sqz_word_t word;
    @(posedge clk);
    if (sqz_credit_o) begin
      if (credits >= `FIFO_DEPTH) begin
        $display("a credit came back while the source already held all of its credits");
        abort_run();
      end
      credits++;
    end
    if (coeff_valid_o) begin
      if (phase != 2 || got >= `COEFF_CNT) begin
        $display("a coefficient came out outside of a running operation");
        abort_run();
      end
      if (exp_coeff.size() == 0) begin
        $display("a coefficient came out before the model could produce it");
        abort_run();
      end
      check_value("coeff", exp_coeff.pop_front(), coeff_o);
      check_value("address", exp_addr.pop_front(), coeff_addr_o);
      got++;
    end
    case (phase)
      1: phase = 2;
      2: begin
        check_value("busy", 1, busy_o);
        check_value("early done", 0, done_o);
        if (got == `COEFF_CNT) begin
          phase = 3;
        end
      end
      3: begin
        check_value("done", 1, done_o);
        check_value("busy at done", 0, busy_o);
        phase = 0;
      end
      default: ;
    endcase
    sqz_valid_i <= 1'b0;
    start_i     <= 1'b0;
    if (phase == 0 && start_req) begin
      start_i     <= 1'b1;
      mode_i      <= cur_mode;
      dest_base_i <= cur_base;
      start_req = 1'b0;
      phase     = 1;
    end else if (phase == 2 && busy_o) begin
      if (credits > 0 && ($random(seed) & 3) != 0) begin
        word = {$random(seed), $random(seed)};
        if (inject_ones && ($random(seed) & 3) == 0) begin
          word = '1;
        end
        sqz_valid_i <= 1'b1;
        sqz_data_i  <= word;
        credits--;
        model_word(word);
      end
      // stray start with other settings that must be ignored
      if (($random(seed) & 15) == 0) begin
        start_i     <= 1'b1;
        mode_i      <= sampler_mode_e'($random(seed) & 1);
        dest_base_i <= addr_t'($random(seed));
      end
    end
  endtask

  task automatic run_operation(input string name, input sampler_mode_e mode,
                               input addr_t base, input bit ones);
    test_name   = name;
    cur_mode    = mode;
    cur_base    = base;
    inject_ones = ones;
    got         = 0;
    produced    = 0;
    mbuf        = '0;
    mbits       = 0;
    exp_coeff.delete();
    exp_addr.delete();
    start_req = 1'b1;
    step_cycle();
    while (phase != 0) begin
      step_cycle();
    end
    repeat (IDLE_GAP) begin
      step_cycle();
    end
    // words dropped by the final clear count too
    check_value("credits", `FIFO_DEPTH, credits);
  endtask

  initial begin
    seed        = 32'h45d76744;
    clk         = 1'b0;
    rst_b       = 1'b0;
    start_i     = 1'b0;
    mode_i      = MODE_UNIFORM;
    dest_base_i = '0;
    sqz_valid_i = 1'b0;
    sqz_data_i  = '0;
    cycle_count = 0;
    credits     = `FIFO_DEPTH;
    phase       = 0;
    start_req   = 1'b0;
    test_name   = "reset";
    repeat (4) @(posedge clk);
    rst_b <= 1'b1;
    @(posedge clk);
    check_value("busy", 0, busy_o);
    check_value("done", 0, done_o);
    check_value("coeff valid", 0, coeff_valid_o);
    check_value("credit", 0, sqz_credit_o);

    run_operation("uniform_random", MODE_UNIFORM, 10'h000, 1'b0);
    run_operation("bounded_a", MODE_BOUNDED, 10'h155, 1'b0);
    run_operation("uniform_all_ones", MODE_UNIFORM, 10'h3c0, 1'b1);
    run_operation("bounded_b", MODE_BOUNDED, 10'h2a0, 1'b0);
    run_operation("uniform_mixed", MODE_UNIFORM, 10'h080, 1'b1);
    run_operation("bounded_wrap", MODE_BOUNDED, 10'h3f0, 1'b0);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sampler_top.f ====
+incdir+hdl
hdl/sampler_pkg.sv
hdl/sampler_ctrl_if.sv
hdl/squeeze_fifo.sv
hdl/chunk_piso.sv
hdl/coeff_sampler.sv
hdl/sampler_ctrl.sv
hdl/sampler_top.sv
bench/sampler_properties.sv
bench/tb_sampler_top.sv
